//--- project.f
hdl/dma_group_pkg.sv
hdl/dma_req_spill.sv
hdl/dma_burst_splitter.sv
hdl/dma_word_backend.sv
hdl/dma_group.sv
bench/dma_group_asserts.sv
bench/dma_group_tb.sv

//--- Makefile
# Verilator build and run for the DMA group testbench

VERILATOR ?= verilator
TOP       ?= dma_group_tb
SEED      ?= 39501
LOG       ?= sim.log
FILELIST  ?= project.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing --assert

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -GSeed=$(SEED)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) \
	  -GSeed=$(SEED) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -qF "*** TEST FAILED ***" $(LOG); then \
	  echo "Simulation failed, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- bench/dma_stimulus.txt
# dst src len (hex) then expected word count on tiles 0 1 2 3 (decimal)
# sources sit 0x200 apart so every tile word traces back to its burst
00000000 80000000 0004 1 0 0 0
0000001c 80000200 0008 0 1 1 0
00000040 80000400 0020 4 4 0 0
000000a4 80000600 0040 4 4 4 4
00000100 80000800 0080 8 8 8 8
00000338 80000a00 000c 1 0 0 2
000007f0 80000c00 0004 0 0 0 1
00000404 80000e00 00fc 15 16 16 16
00000fe0 80001000 0020 0 0 4 4
00000210 80001200 0030 0 4 4 4
0000060c 80001400 0018 1 4 1 0
00000008 80001600 0100 16 16 16 16
000009c0 80001800 0010 4 0 0 0
00000c14 80001a00 002c 0 3 4 4
00000e00 80001c00 0020 4 4 0 0

//--- bench/dma_group_tb.sv
// ----------------------------------------
// DMA group testbench
// Replays bursts from a file, checks tile words
// ----------------------------------------

`timescale 1ns/100ps
`default_nettype none

module dma_group_tb #(
  parameter int Seed = 39501
);

  localparam int NumTiles  = dma_group_pkg::NumTilesPerGroup;
  localparam int MaxBursts = 32;
  localparam int MaxWords  = 64;
  localparam int Timeout   = 5000;

  logic                                    clk_i = 1'b0;
  logic                                    rst_i;
  logic                                    burst_valid_i;
  logic                                    burst_ready_o;
  dma_group_pkg::addr_t                    burst_dst_i, burst_src_i;
  dma_group_pkg::len_t                     burst_len_i;
  logic                     [NumTiles-1:0] tile_req_valid_o, tile_req_ready_i;
  dma_group_pkg::tgt_addr_t [NumTiles-1:0] tile_req_tgt_o;
  dma_group_pkg::addr_t     [NumTiles-1:0] tile_req_src_o;
  logic                                    idle_o, done_o;

  // Bursts and expected counts
  dma_group_pkg::addr_t b_dst [MaxBursts];
  dma_group_pkg::addr_t b_src [MaxBursts];
  dma_group_pkg::addr_t b_len [MaxBursts];
  int                   exp_cnt [MaxBursts][NumTiles];
  int                   num_bursts = 0;

  // Observed traffic
  int                       got_cnt [MaxBursts][NumTiles];
  int                       words_seen [MaxBursts];
  bit                       word_seen [MaxBursts][MaxWords];
  int                       done_cnt = 0;
  logic [NumTiles-1:0]      prev_stall;
  dma_group_pkg::tgt_addr_t prev_tgt [NumTiles];
  dma_group_pkg::addr_t     prev_src [NumTiles];

  int     value_errors = 0;
  int     other_errors = 0;
  bit     aborted = 1'b0;
  integer seed;
  integer rnd;
  int     ready_cycle;

  dma_group dma_group_i (
    .clk_i           (clk_i),
    .rst_i           (rst_i),
    .burst_valid_i   (burst_valid_i),
    .burst_ready_o   (burst_ready_o),
    .burst_dst_i     (burst_dst_i),
    .burst_src_i     (burst_src_i),
    .burst_len_i     (burst_len_i),
    .tile_req_valid_o(tile_req_valid_o),
    .tile_req_ready_i(tile_req_ready_i),
    .tile_req_tgt_o  (tile_req_tgt_o),
    .tile_req_src_o  (tile_req_src_o),
    .idle_o          (idle_o),
    .done_o          (done_o)
  );

  always #2 clk_i = ~clk_i;

  // Random tile ready in light and heavy stall phases of 64 cycles
  initial begin
    seed             = Seed;
    ready_cycle      = 0;
    tile_req_ready_i = '0;
    forever begin
      @(negedge clk_i);
      ready_cycle++;
      for (int t = 0; t < NumTiles; t++) begin
        rnd = $random(seed);
        if (rst_i) begin
          tile_req_ready_i[t] = 1'b0;
        end else if (ready_cycle[6]) begin
          tile_req_ready_i[t] = rnd[2:0] < 3'd3;
        end else begin
          tile_req_ready_i[t] = rnd[2:0] != 3'd0;
        end
      end
    end
  end

  task automatic load_stimulus();
    int                   fd;
    int                   n;
    string                line;
    dma_group_pkg::addr_t d, s, l;
    int                   c0, c1, c2, c3;
    fd = $fopen("bench/dma_stimulus.txt", "r");
    if (fd == 0) begin
      $display("Could not open the stimulus file bench/dma_stimulus.txt");
      other_errors++;
      aborted = 1'b1;
    end else begin
      while ($fgets(line, fd) != 0) begin
        n = $sscanf(line, "%h %h %h %d %d %d %d", d, s, l, c0, c1, c2, c3);
        if (n == 7 && num_bursts < MaxBursts) begin
          if (l == '0 || l[1:0] != 2'b00 || l > 32'(MaxWords * 4) ||
              c0 + c1 + c2 + c3 != int'(l >> 2)) begin
            $display("Stimulus burst %0d is inconsistent: %s", num_bursts, line);
            other_errors++;
            aborted = 1'b1;
          end
          b_dst[num_bursts]      = d;
          b_src[num_bursts]      = s;
          b_len[num_bursts]      = l;
          exp_cnt[num_bursts][0] = c0;
          exp_cnt[num_bursts][1] = c1;
          exp_cnt[num_bursts][2] = c2;
          exp_cnt[num_bursts][3] = c3;
          num_bursts++;
        end else if (n > 0) begin
          $display("Stimulus line could not be parsed: %s", line);
          other_errors++;
          aborted = 1'b1;
        end
      end
      $fclose(fd);
      if (num_bursts == 0) begin
        $display("The stimulus file holds no bursts");
        other_errors++;
        aborted = 1'b1;
      end
    end
  endtask

  // Trace a tile word back to its burst by source address
  task automatic record_word(input int t);
    int                       idx;
    int                       word;
    dma_group_pkg::addr_t     src, off, dst;
    dma_group_pkg::tgt_addr_t exp_tgt;
    dma_group_pkg::tile_idx_t exp_tile;
    idx = -1;
    src = tile_req_src_o[t];
    for (int i = 0; i < num_bursts; i++) begin
      if (src >= b_src[i] && src < b_src[i] + b_len[i]) begin
        idx = i;
      end
    end
    if (idx < 0) begin
      $display("Tile %0d sent source %h that belongs to no burst at %0t", t, src, $time);
      other_errors++;
    end else begin
      off      = src - b_src[idx];
      dst      = b_dst[idx] + off;
      word     = int'(off >> 2);
      exp_tgt  = {dst[11:6], dst[3:2]};
      exp_tile = dst[5:4];
      if (dma_group_pkg::tile_idx_t'(t) != exp_tile) begin
        $display("ERROR t=%0t tile_req_valid_o index for dst %h: got %0d expected %0d",
                 $time, dst, t, exp_tile);
        value_errors++;
      end
      if (tile_req_tgt_o[t] != exp_tgt) begin
        $display("ERROR t=%0t tile_req_tgt_o[%0d]: got %h expected %h",
                 $time, t, tile_req_tgt_o[t], exp_tgt);
        value_errors++;
      end
      if (word_seen[idx][word]) begin
        $display("Burst %0d word %0d was delivered twice at %0t", idx, word, $time);
        other_errors++;
      end else begin
        word_seen[idx][word] = 1'b1;
        words_seen[idx]++;
        got_cnt[idx][t]++;
      end
    end
  endtask

  task send_burst(input int i);
    int waited;
    @(negedge clk_i);
    burst_dst_i   = b_dst[i];
    burst_src_i   = b_src[i];
    burst_len_i   = b_len[i][15:0];
    burst_valid_i = 1'b1;
    #1;
    waited = 0;
    while (!burst_ready_o && waited < Timeout) begin
      @(negedge clk_i);
      #1;
      waited++;
    end
    if (!burst_ready_o) begin
      $display("Burst %0d was not accepted within %0d cycles", i, Timeout);
      other_errors++;
      aborted = 1'b1;
    end
  endtask

  task automatic check_reset();
    if (tile_req_valid_o !== '0) begin
      $display("ERROR t=%0t tile_req_valid_o: got %b expected %b",
               $time, tile_req_valid_o, {NumTiles{1'b0}});
      value_errors++;
    end
    if (done_o !== 1'b0) begin
      $display("ERROR t=%0t done_o: got %b expected 0", $time, done_o);
      value_errors++;
    end
    if (idle_o !== 1'b1) begin
      $display("ERROR t=%0t idle_o: got %b expected 1", $time, idle_o);
      value_errors++;
    end
    if (burst_ready_o !== 1'b1) begin
      $display("ERROR t=%0t burst_ready_o: got %b expected 1", $time, burst_ready_o);
      value_errors++;
    end
  endtask

  task automatic check_counts();
    for (int i = 0; i < num_bursts; i++) begin
      for (int t = 0; t < NumTiles; t++) begin
        if (got_cnt[i][t] != exp_cnt[i][t]) begin
          $display("ERROR t=%0t tile_req_valid_o[%0d] words of burst %0d: got %0d expected %0d",
                   $time, t, i, got_cnt[i][t], exp_cnt[i][t]);
          value_errors++;
        end
      end
      if (words_seen[i] != int'(b_len[i] >> 2)) begin
        $display("Burst %0d delivered %0d of %0d destination words",
                 i, words_seen[i], int'(b_len[i] >> 2));
        other_errors++;
      end
    end
  endtask

  // ----------------------------------------
  // Monitor sampling in the low clock phase
  // ----------------------------------------
  initial begin
    prev_stall = '0;
    for (int i = 0; i < MaxBursts; i++) begin
      words_seen[i] = 0;
      for (int t = 0; t < NumTiles; t++) begin
        got_cnt[i][t] = 0;
      end
      for (int w = 0; w < MaxWords; w++) begin
        word_seen[i][w] = 1'b0;
      end
    end
    forever begin
      @(negedge clk_i);
      #1;
      if (!rst_i) begin
        for (int t = 0; t < NumTiles; t++) begin
          if (prev_stall[t]) begin
            if (!tile_req_valid_o[t]) begin
              $display("Tile %0d dropped its request while stalled at %0t", t, $time);
              other_errors++;
            end else if (tile_req_tgt_o[t] != prev_tgt[t]) begin
              $display("ERROR t=%0t tile_req_tgt_o[%0d]: got %h expected %h",
                       $time, t, tile_req_tgt_o[t], prev_tgt[t]);
              value_errors++;
            end else if (tile_req_src_o[t] != prev_src[t]) begin
              $display("ERROR t=%0t tile_req_src_o[%0d]: got %h expected %h",
                       $time, t, tile_req_src_o[t], prev_src[t]);
              value_errors++;
            end
          end
          if (tile_req_valid_o[t] && tile_req_ready_i[t]) begin
            record_word(t);
          end
          prev_stall[t] = tile_req_valid_o[t] && !tile_req_ready_i[t];
          prev_tgt[t]   = tile_req_tgt_o[t];
          prev_src[t]   = tile_req_src_o[t];
        end
        // Done pulses retire bursts in order
        if (done_o) begin
          if (done_cnt >= num_bursts) begin
            $display("done_o pulsed at %0t with no burst left", $time);
            other_errors++;
          end else begin
            if (words_seen[done_cnt] != int'(b_len[done_cnt] >> 2)) begin
              $display("done_o for burst %0d came after only %0d of %0d words at %0t",
                       done_cnt, words_seen[done_cnt], int'(b_len[done_cnt] >> 2), $time);
              other_errors++;
            end
            done_cnt++;
          end
        end
      end
    end
  end

  // ----------------------------------------
  // Main sequence
  // ----------------------------------------
  initial begin
    int waited;
    int gap;
    rst_i         = 1'b1;
    burst_valid_i = 1'b0;
    burst_dst_i   = '0;
    burst_src_i   = '0;
    burst_len_i   = '0;
    load_stimulus();
    repeat (10) @(posedge clk_i);
    @(negedge clk_i);
    rst_i = 1'b0;
    #1;
    check_reset();

    for (int i = 0; i < num_bursts && !aborted; i++) begin
      send_burst(i);
      gap = i % 3;
      if (gap != 0) begin
        @(negedge clk_i);
        burst_valid_i = 1'b0;
        repeat (gap - 1) @(negedge clk_i);
      end
    end
    @(negedge clk_i);
    burst_valid_i = 1'b0;

    if (!aborted) begin
      waited = 0;
      while (done_cnt < num_bursts && waited < Timeout) begin
        @(negedge clk_i);
        waited++;
      end
      if (done_cnt < num_bursts) begin
        $display("Only %0d of %0d bursts signalled done_o within %0d cycles",
                 done_cnt, num_bursts, Timeout);
        other_errors++;
        aborted = 1'b1;
      end
    end
    if (!aborted) begin
      waited = 0;
      while (!idle_o && waited < Timeout) begin
        @(negedge clk_i);
        waited++;
      end
      if (!idle_o) begin
        $display("idle_o did not return high within %0d cycles", Timeout);
        other_errors++;
      end
      check_counts();
    end

    $display("Run finished: %0d value errors, %0d other errors, %0d of %0d bursts done",
             value_errors, other_errors, done_cnt, num_bursts);
    if (value_errors == 0 && other_errors == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- bench/dma_group_asserts.sv
// ----------------------------------------
// DMA group assertions
// Tile handshake and status properties
// ----------------------------------------

`timescale 1ns/100ps
`default_nettype none

module dma_group_asserts (
  input logic                                                           clk_i,
  input logic                                                           rst_i,
  input logic                     [dma_group_pkg::NumTilesPerGroup-1:0] tile_req_valid_o,
  input logic                     [dma_group_pkg::NumTilesPerGroup-1:0] tile_req_ready_i,
  input dma_group_pkg::tgt_addr_t [dma_group_pkg::NumTilesPerGroup-1:0] tile_req_tgt_o,
  input dma_group_pkg::addr_t     [dma_group_pkg::NumTilesPerGroup-1:0] tile_req_src_o,
  input logic                                                           idle_o,
  input logic                                                           done_o
);

  // A stalled request keeps valid and payload
  for (genvar t = 0; t < dma_group_pkg::NumTilesPerGroup; t++) begin : gen_tiles
    a_req_stable: assert property (@(posedge clk_i) disable iff (rst_i)
      tile_req_valid_o[t] && !tile_req_ready_i[t] |=>
        tile_req_valid_o[t] && $stable(tile_req_tgt_o[t]) && $stable(tile_req_src_o[t]))
      else $error("tile %0d request changed while stalled", t);
  end

  a_done_pulse: assert property (@(posedge clk_i) disable iff (rst_i) done_o |=> !done_o)
    else $error("done_o high for two cycles in a row");

  a_idle_quiet: assert property (@(posedge clk_i) disable iff (rst_i)
    idle_o |-> !(|tile_req_valid_o))
    else $error("idle_o high while a tile request is pending");

endmodule

bind dma_group dma_group_asserts i_asserts (.*);

`default_nettype wire

//--- hdl/dma_group.sv
// -------------------------------------
// DMA group top level
// Spill register, midend and per-unit backends
// -------------------------------------

`timescale 1ns/100ps
`default_nettype none

module dma_group (
  input  logic                                                             clk_i,
  input  logic                                                             rst_i,
  input  logic                                                             burst_valid_i,
  output logic                                                             burst_ready_o,
  input  dma_group_pkg::addr_t                                             burst_dst_i,
  input  dma_group_pkg::addr_t                                             burst_src_i,
  input  dma_group_pkg::len_t                                              burst_len_i,
  output logic                     [dma_group_pkg::NumTilesPerGroup-1:0]   tile_req_valid_o,
  input  logic                     [dma_group_pkg::NumTilesPerGroup-1:0]   tile_req_ready_i,
  output dma_group_pkg::tgt_addr_t [dma_group_pkg::NumTilesPerGroup-1:0]   tile_req_tgt_o,
  output dma_group_pkg::addr_t     [dma_group_pkg::NumTilesPerGroup-1:0]   tile_req_src_o,
  output logic                                                             idle_o,
  output logic                                                             done_o
);

  logic                 req_valid, req_ready, spill_empty;
  dma_group_pkg::addr_t req_dst, req_src;
  dma_group_pkg::len_t  req_len;

  logic                 [dma_group_pkg::NumDmasPerGroup-1:0] piece_valid, piece_ready;
  dma_group_pkg::addr_t [dma_group_pkg::NumDmasPerGroup-1:0] piece_dst, piece_src;
  dma_group_pkg::len_t  [dma_group_pkg::NumDmasPerGroup-1:0] piece_len;
  logic                 [dma_group_pkg::NumDmasPerGroup-1:0] piece_done, busy;

  dma_req_spill i_spill (
    .clk_i      (clk_i),
    .rst_i      (rst_i),
    .in_valid_i (burst_valid_i),
    .in_dst_i   (burst_dst_i),
    .in_src_i   (burst_src_i),
    .in_len_i   (burst_len_i),
    .in_ready_o (burst_ready_o),
    .out_valid_o(req_valid),
    .out_ready_i(req_ready),
    .out_dst_o  (req_dst),
    .out_src_o  (req_src),
    .out_len_o  (req_len),
    .empty_o    (spill_empty)
  );

  dma_burst_splitter i_splitter (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .req_valid_i  (req_valid),
    .req_dst_i    (req_dst),
    .req_src_i    (req_src),
    .req_len_i    (req_len),
    .req_ready_o  (req_ready),
    .piece_valid_o(piece_valid),
    .piece_ready_i(piece_ready),
    .piece_dst_o  (piece_dst),
    .piece_src_o  (piece_src),
    .piece_len_o  (piece_len),
    .piece_done_i (piece_done),
    .busy_i       (busy),
    .spill_empty_i(spill_empty),
    .idle_o       (idle_o),
    .done_o       (done_o)
  );

  // Unit d owns tiles d*NumTilesPerDma and up
  for (genvar d = 0; d < dma_group_pkg::NumDmasPerGroup; d++) begin : gen_dmas
    dma_word_backend #(
      .DmaIdx(dma_group_pkg::dma_idx_t'(d))
    ) i_backend (
      .clk_i        (clk_i),
      .rst_i        (rst_i),
      .piece_valid_i(piece_valid[d]),
      .piece_dst_i  (piece_dst[d]),
      .piece_src_i  (piece_src[d]),
      .piece_len_i  (piece_len[d]),
      .piece_ready_o(piece_ready[d]),
      .tile_valid_o (tile_req_valid_o[d*dma_group_pkg::NumTilesPerDma +:
                                      dma_group_pkg::NumTilesPerDma]),
      .tile_ready_i (tile_req_ready_i[d*dma_group_pkg::NumTilesPerDma +:
                                      dma_group_pkg::NumTilesPerDma]),
      .tile_tgt_o   (tile_req_tgt_o[d*dma_group_pkg::NumTilesPerDma +:
                                    dma_group_pkg::NumTilesPerDma]),
      .tile_src_o   (tile_req_src_o[d*dma_group_pkg::NumTilesPerDma +:
                                    dma_group_pkg::NumTilesPerDma]),
      .piece_done_o (piece_done[d]),
      .busy_o       (busy[d])
    );
  end

endmodule

`default_nettype wire

//--- hdl/dma_word_backend.sv
// -------------------------------------
// DMA word backend
// Walks a piece word by word onto tile ports
// -------------------------------------

`timescale 1ns/100ps
`default_nettype none

module dma_word_backend #(
  parameter dma_group_pkg::dma_idx_t DmaIdx = '0
) (
  input  logic                                                           clk_i,
  input  logic                                                           rst_i,
  input  logic                                                           piece_valid_i,
  input  dma_group_pkg::addr_t                                           piece_dst_i,
  input  dma_group_pkg::addr_t                                           piece_src_i,
  input  dma_group_pkg::len_t                                            piece_len_i,
  output logic                                                           piece_ready_o,
  output logic                     [dma_group_pkg::NumTilesPerDma-1:0]   tile_valid_o,
  input  logic                     [dma_group_pkg::NumTilesPerDma-1:0]   tile_ready_i,
  output dma_group_pkg::tgt_addr_t [dma_group_pkg::NumTilesPerDma-1:0]   tile_tgt_o,
  output dma_group_pkg::addr_t     [dma_group_pkg::NumTilesPerDma-1:0]   tile_src_o,
  output logic                                                           piece_done_o,
  output logic                                                           busy_o
);

  typedef logic [dma_group_pkg::TileSelWidth-1:0] tile_sel_t;

  logic                 active_q;
  dma_group_pkg::addr_t dst_q, src_q;
  dma_group_pkg::len_t  words_q;

  dma_group_pkg::addr_t                         tcdm_off;
  dma_group_pkg::tile_idx_t                     tile_idx;
  tile_sel_t                                    tile_sel;
  logic [dma_group_pkg::BankIdxWidth-1:0]       bank;
  logic [dma_group_pkg::RowWidth-1:0]           row;
  logic                                         accept, word_fire, last_word;

  // Address remap puts the bank lowest, then the tile, then the row
  assign tcdm_off = dst_q - dma_group_pkg::TcdmBaseAddr;
  assign bank     = tcdm_off[dma_group_pkg::ByteOffset +: dma_group_pkg::BankIdxWidth];
  assign tile_idx = tcdm_off[dma_group_pkg::ByteOffset + dma_group_pkg::BankIdxWidth +:
                             dma_group_pkg::TileIdxWidth];
  assign row      = tcdm_off[dma_group_pkg::ByteOffset + dma_group_pkg::BankIdxWidth +
                             dma_group_pkg::TileIdxWidth +: dma_group_pkg::RowWidth];
  // Local port of this unit among its own tiles
  assign tile_sel = tile_sel_t'(tile_idx -
                    dma_group_pkg::tile_idx_t'(DmaIdx * dma_group_pkg::NumTilesPerDma));

  assign piece_ready_o = !active_q;
  assign accept        = piece_valid_i && piece_ready_o;
  assign word_fire     = active_q && tile_ready_i[tile_sel];
  assign last_word     = words_q == dma_group_pkg::len_t'(1);
  assign piece_done_o  = word_fire && last_word;
  assign busy_o        = active_q;

  always_comb begin
    for (int t = 0; t < dma_group_pkg::NumTilesPerDma; t++) begin
      tile_valid_o[t] = active_q && (tile_sel == tile_sel_t'(t));
      tile_tgt_o[t]   = {row, bank};
      tile_src_o[t]   = src_q;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      active_q <= 1'b0;
    end else if (accept) begin
      active_q <= 1'b1;
    end else if (piece_done_o) begin
      active_q <= 1'b0;
    end
  end

  // Word walk
  always_ff @(posedge clk_i) begin
    if (accept) begin
      dst_q   <= piece_dst_i;
      src_q   <= piece_src_i;
      words_q <= piece_len_i >> dma_group_pkg::ByteOffset;
    end else if (word_fire) begin
      dst_q   <= dst_q + dma_group_pkg::addr_t'(2 ** dma_group_pkg::ByteOffset);
      src_q   <= src_q + dma_group_pkg::addr_t'(2 ** dma_group_pkg::ByteOffset);
      words_q <= words_q - dma_group_pkg::len_t'(1);
    end
  end

endmodule

`default_nettype wire

//--- hdl/dma_burst_splitter.sv
// -------------------------------------
// DMA distributed midend
// Cuts bursts at region edges, signals done
// -------------------------------------

`timescale 1ns/100ps
`default_nettype none

module dma_burst_splitter (
  input  logic                                                        clk_i,
  input  logic                                                        rst_i,
  input  logic                                                        req_valid_i,
  input  dma_group_pkg::addr_t                                        req_dst_i,
  input  dma_group_pkg::addr_t                                        req_src_i,
  input  dma_group_pkg::len_t                                         req_len_i,
  output logic                                                        req_ready_o,
  output logic                 [dma_group_pkg::NumDmasPerGroup-1:0]   piece_valid_o,
  input  logic                 [dma_group_pkg::NumDmasPerGroup-1:0]   piece_ready_i,
  output dma_group_pkg::addr_t [dma_group_pkg::NumDmasPerGroup-1:0]   piece_dst_o,
  output dma_group_pkg::addr_t [dma_group_pkg::NumDmasPerGroup-1:0]   piece_src_o,
  output dma_group_pkg::len_t  [dma_group_pkg::NumDmasPerGroup-1:0]   piece_len_o,
  input  logic                 [dma_group_pkg::NumDmasPerGroup-1:0]   piece_done_i,
  input  logic                 [dma_group_pkg::NumDmasPerGroup-1:0]   busy_i,
  input  logic                                                        spill_empty_i,
  output logic                                                        idle_o,
  output logic                                                        done_o
);

  // Burst currently being cut
  logic                      cur_valid_q;
  dma_group_pkg::addr_t      cur_dst_q, cur_src_q;
  dma_group_pkg::len_t       cur_len_q;
  dma_group_pkg::burst_tag_t cur_tag_q;

  dma_group_pkg::addr_t      region_off;
  dma_group_pkg::len_t       room, piece_len;
  dma_group_pkg::dma_idx_t   tgt_unit;
  logic                      piece_last, issue, accept, retire;

  // In-order table of outstanding pieces per burst
  dma_group_pkg::burst_tag_t  wr_ptr_q, rd_ptr_q;
  dma_group_pkg::burst_fill_t fill_q;
  dma_group_pkg::piece_cnt_t  cnt_q [dma_group_pkg::BurstFifoDepth];
  dma_group_pkg::piece_cnt_t  cnt_d [dma_group_pkg::BurstFifoDepth];
  logic [dma_group_pkg::BurstFifoDepth-1:0] closed_q, closed_d;
  dma_group_pkg::burst_tag_t  tag_q [dma_group_pkg::NumDmasPerGroup];

  assign region_off = cur_dst_q - dma_group_pkg::TcdmBaseAddr;
  assign room = dma_group_pkg::len_t'(dma_group_pkg::DmaRegionWidth -
                (region_off % dma_group_pkg::DmaRegionWidth));
  assign piece_last = cur_len_q <= room;
  assign piece_len  = piece_last ? cur_len_q : room;
  assign tgt_unit   = dma_group_pkg::dma_idx_t'((region_off / dma_group_pkg::DmaRegionWidth) %
                      dma_group_pkg::NumDmasPerGroup);

  assign issue  = cur_valid_q && piece_ready_i[tgt_unit];
  assign accept = req_valid_i && req_ready_o;
  // Next burst is taken as soon as the last piece leaves
  assign req_ready_o = (!cur_valid_q || (issue && piece_last)) &&
                       (fill_q != dma_group_pkg::burst_fill_t'(dma_group_pkg::BurstFifoDepth));

  always_comb begin
    for (int d = 0; d < dma_group_pkg::NumDmasPerGroup; d++) begin
      piece_valid_o[d] = cur_valid_q && (tgt_unit == dma_group_pkg::dma_idx_t'(d));
      piece_dst_o[d]   = cur_dst_q;
      piece_src_o[d]   = cur_src_q;
      piece_len_o[d]   = piece_len;
    end
  end

  always_comb begin
    cnt_d    = cnt_q;
    closed_d = closed_q;
    if (accept) begin
      cnt_d[wr_ptr_q]    = '0;
      closed_d[wr_ptr_q] = 1'b0;
    end
    if (issue) begin
      cnt_d[cur_tag_q] = cnt_d[cur_tag_q] + dma_group_pkg::piece_cnt_t'(1);
      if (piece_last) begin
        closed_d[cur_tag_q] = 1'b1;
      end
    end
    for (int d = 0; d < dma_group_pkg::NumDmasPerGroup; d++) begin
      if (piece_done_i[d]) begin
        cnt_d[tag_q[d]] = cnt_d[tag_q[d]] - dma_group_pkg::piece_cnt_t'(1);
      end
    end
  end

  // Head burst retires once fully cut and every piece has finished
  // Retires are spaced so that done_o stays a single-cycle pulse
  assign retire = (fill_q != '0) && closed_d[rd_ptr_q] && (cnt_d[rd_ptr_q] == '0) &&
                  !done_o;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      cur_valid_q <= 1'b0;
      wr_ptr_q    <= '0;
      rd_ptr_q    <= '0;
      fill_q      <= '0;
      cnt_q       <= '{default: '0};
      closed_q    <= '0;
      done_o      <= 1'b0;
      idle_o      <= 1'b1;
    end else begin
      if (accept) begin
        cur_valid_q <= 1'b1;
        wr_ptr_q    <= wr_ptr_q + dma_group_pkg::burst_tag_t'(1);
      end else if (issue && piece_last) begin
        cur_valid_q <= 1'b0;
      end
      if (retire) begin
        rd_ptr_q <= rd_ptr_q + dma_group_pkg::burst_tag_t'(1);
      end
      fill_q   <= fill_q + dma_group_pkg::burst_fill_t'(accept) -
                  dma_group_pkg::burst_fill_t'(retire);
      cnt_q    <= cnt_d;
      closed_q <= closed_d;
      done_o   <= retire;
      idle_o   <= spill_empty_i && !cur_valid_q && !(|busy_i);
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      cur_dst_q <= req_dst_i;
      cur_src_q <= req_src_i;
      cur_len_q <= req_len_i;
      cur_tag_q <= wr_ptr_q;
    end else if (issue) begin
      cur_dst_q <= cur_dst_q + dma_group_pkg::addr_t'(piece_len);
      cur_src_q <= cur_src_q + dma_group_pkg::addr_t'(piece_len);
      cur_len_q <= cur_len_q - piece_len;
    end
    for (int d = 0; d < dma_group_pkg::NumDmasPerGroup; d++) begin
      if (issue && (tgt_unit == dma_group_pkg::dma_idx_t'(d))) begin
        tag_q[d] <= cur_tag_q;
      end
    end
  end

endmodule

`default_nettype wire

//--- hdl/dma_req_spill.sv
// -------------------------------------
// DMA request spill register
// Two slots, full throughput, registered ready
// -------------------------------------

`timescale 1ns/100ps
`default_nettype none

module dma_req_spill (
  input  logic                 clk_i,
  input  logic                 rst_i,
  input  logic                 in_valid_i,
  input  dma_group_pkg::addr_t in_dst_i,
  input  dma_group_pkg::addr_t in_src_i,
  input  dma_group_pkg::len_t  in_len_i,
  output logic                 in_ready_o,
  output logic                 out_valid_o,
  input  logic                 out_ready_i,
  output dma_group_pkg::addr_t out_dst_o,
  output dma_group_pkg::addr_t out_src_o,
  output dma_group_pkg::len_t  out_len_o,
  output logic                 empty_o
);

  // Slot a takes new requests, slot b holds one that stalled downstream
  logic                 a_full_q, b_full_q;
  dma_group_pkg::addr_t a_dst_q, a_src_q, b_dst_q, b_src_q;
  dma_group_pkg::len_t  a_len_q, b_len_q;
  logic                 a_fill, a_drain, b_fill, b_drain;

  assign a_fill  = in_valid_i && in_ready_o;
  assign a_drain = a_full_q && !b_full_q;
  assign b_fill  = a_drain && !out_ready_i;
  assign b_drain = b_full_q && out_ready_i;

  assign in_ready_o  = !(a_full_q && b_full_q);
  assign out_valid_o = a_full_q || b_full_q;
  assign empty_o     = !a_full_q && !b_full_q;

  // Older entry sits in b whenever b is full
  assign out_dst_o = b_full_q ? b_dst_q : a_dst_q;
  assign out_src_o = b_full_q ? b_src_q : a_src_q;
  assign out_len_o = b_full_q ? b_len_q : a_len_q;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      a_full_q <= 1'b0;
      b_full_q <= 1'b0;
    end else begin
      if (a_fill || a_drain) begin
        a_full_q <= a_fill;
      end
      if (b_fill || b_drain) begin
        b_full_q <= b_fill;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (a_fill) begin
      a_dst_q <= in_dst_i;
      a_src_q <= in_src_i;
      a_len_q <= in_len_i;
    end
    if (b_fill) begin
      b_dst_q <= a_dst_q;
      b_src_q <= a_src_q;
      b_len_q <= a_len_q;
    end
  end

endmodule

`default_nettype wire

//--- hdl/dma_group_pkg.sv
// -------------------------------------
// DMA group package
// Group geometry and address field widths
// -------------------------------------

`default_nettype none

package dma_group_pkg;

  // Address geometry
  localparam int unsigned AddrWidth  = 32;
  localparam int unsigned LenWidth   = 16;
  localparam int unsigned ByteOffset = 2;

  // Group layout
  localparam int unsigned NumTilesPerGroup = 4;
  localparam int unsigned NumDmasPerGroup  = 2;
  localparam int unsigned NumTilesPerDma   = NumTilesPerGroup / NumDmasPerGroup;
  localparam int unsigned NumBanksPerTile  = 4;

  // TCDM window
  localparam int unsigned TcdmBaseAddr = 32'h0000_0000;
  localparam int unsigned TcdmSize     = 4096;

  // Smallest address span in bytes owned by one DMA unit
  localparam int unsigned DmaRegionWidth =
    NumTilesPerGroup * NumBanksPerTile * (2 ** ByteOffset) / NumDmasPerGroup;

  // Fields of a TCDM byte address from low to high
  localparam int unsigned BankIdxWidth = $clog2(NumBanksPerTile);
  localparam int unsigned TileIdxWidth = $clog2(NumTilesPerGroup);
  localparam int unsigned TileSelWidth = $clog2(NumTilesPerDma);
  localparam int unsigned RowWidth =
    $clog2(TcdmSize) - ByteOffset - BankIdxWidth - TileIdxWidth;

  // Bursts in flight between split and done
  localparam int unsigned BurstFifoDepth = 4;

  typedef logic [AddrWidth-1:0]               addr_t;
  typedef logic [LenWidth-1:0]                len_t;
  typedef logic [TileIdxWidth-1:0]            tile_idx_t;
  typedef logic [RowWidth+BankIdxWidth-1:0]   tgt_addr_t;
  typedef logic [$clog2(NumDmasPerGroup)-1:0] dma_idx_t;

  typedef logic [$clog2(BurstFifoDepth)-1:0]   burst_tag_t;
  typedef logic [$clog2(BurstFifoDepth+1)-1:0] burst_fill_t;
  typedef logic [$clog2(NumDmasPerGroup+1)-1:0] piece_cnt_t;

endpackage

`default_nettype wire
